//--- verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// --------------------------------------------------
	// Bus widths
	// --------------------------------------------------
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// --------------------------------------------------
	// Address map, matched on address bits 31..24
	// --------------------------------------------------
	localparam logic [7:0] REGION_MEM = 8'h00;
	localparam logic [7:0] REGION_ALU = 8'h10;
	localparam logic [7:0] REGION_MUL = 8'h20;

	// Target of a decoded request
	typedef enum logic [1:0] {
		SEL_MEM,
		SEL_ALU,
		SEL_MUL,
		SEL_NONE
	} slave_sel_e;

	// Response code, kept from the AHB HRESP encoding
	typedef enum logic {
		RESP_OKAY,
		RESP_ERROR
	} resp_e;

endpackage

`default_nettype wire

//--- verilog/periph_pkg.sv
`default_nettype none

package periph_pkg;

	// --------------------------------------------------
	// ALU opcodes
	// --------------------------------------------------
	// SLT compares signed, shifts use B[4:0]
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SLT
	} alu_op_e;

	// --------------------------------------------------
	// Register offsets, from address bits 3..2
	// --------------------------------------------------
	localparam int REG_OFF_W = 2;

	localparam logic [REG_OFF_W-1:0] ALU_OFF_A   = 2'd0;
	localparam logic [REG_OFF_W-1:0] ALU_OFF_B   = 2'd1;
	localparam logic [REG_OFF_W-1:0] ALU_OFF_OP  = 2'd2;
	localparam logic [REG_OFF_W-1:0] ALU_OFF_RES = 2'd3;

	localparam logic [REG_OFF_W-1:0] MUL_OFF_A  = 2'd0;
	localparam logic [REG_OFF_W-1:0] MUL_OFF_B  = 2'd1;
	localparam logic [REG_OFF_W-1:0] MUL_OFF_LO = 2'd2;
	localparam logic [REG_OFF_W-1:0] MUL_OFF_HI = 2'd3;

	// Data RAM, word index from address bits 9..2
	localparam int MEM_DEPTH = 256;
	localparam int MEM_AW    = 8;

endpackage

`default_nettype wire

//--- verilog/alu_periph.sv
`timescale 1ns/1ps
`default_nettype none

module alu_periph
	import bus_pkg::*, periph_pkg::*;
(
	input  wire                   i_hclk,
	input  wire                   i_rst_n,
	input  wire                   i_acc,
	input  wire                   i_write,
	input  wire   [REG_OFF_W-1:0] i_off,
	input  wire   [DATA_W-1:0]    i_wdata,
	output logic  [DATA_W-1:0]    o_rdata
);

	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	alu_op_e           op;
	logic [DATA_W-1:0] result;

	// Result follows the operands directly
	always_comb begin
		case (op)
			ALU_ADD: result = op_a + op_b;
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR:  result = op_a | op_b;
			ALU_XOR: result = op_a ^ op_b;
			ALU_SLL: result = op_a << op_b[4:0];
			ALU_SRL: result = op_a >> op_b[4:0];
			default: result = {{(DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
		endcase
	end

	always_ff @(posedge i_hclk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			op_a    <= '0;
			op_b    <= '0;
			op      <= ALU_ADD;
			o_rdata <= '0;
		end else if (i_acc && i_write) begin
			case (i_off)
				ALU_OFF_A:  op_a <= i_wdata;
				ALU_OFF_B:  op_b <= i_wdata;
				ALU_OFF_OP: op   <= alu_op_e'(i_wdata[2:0]);
				default: ;
			endcase
		end else if (i_acc) begin
			case (i_off)
				ALU_OFF_A:  o_rdata <= op_a;
				ALU_OFF_B:  o_rdata <= op_b;
				ALU_OFF_OP: o_rdata <= {{(DATA_W-3){1'b0}}, op};
				default:    o_rdata <= result;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/mul_periph.sv
`timescale 1ns/1ps
`default_nettype none

module mul_periph
	import bus_pkg::*, periph_pkg::*;
(
	input  wire                   i_hclk,
	input  wire                   i_rst_n,
	input  wire                   i_acc,
	input  wire                   i_write,
	input  wire   [REG_OFF_W-1:0] i_off,
	input  wire   [DATA_W-1:0]    i_wdata,
	output logic  [DATA_W-1:0]    o_rdata
);

	logic [DATA_W-1:0]   op_a;
	logic [DATA_W-1:0]   op_b;
	logic [2*DATA_W-1:0] product;

	// Unsigned, full width
	assign product = op_a * op_b;

	always_ff @(posedge i_hclk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			op_a    <= '0;
			op_b    <= '0;
			o_rdata <= '0;
		end else if (i_acc && i_write) begin
			if (i_off == MUL_OFF_A) begin
				op_a <= i_wdata;
			end else if (i_off == MUL_OFF_B) begin
				op_b <= i_wdata;
			end
		end else if (i_acc) begin
			case (i_off)
				MUL_OFF_A:  o_rdata <= op_a;
				MUL_OFF_B:  o_rdata <= op_b;
				MUL_OFF_LO: o_rdata <= product[DATA_W-1:0];
				default:    o_rdata <= product[2*DATA_W-1:DATA_W];
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram
	import bus_pkg::*, periph_pkg::*;
(
	input  wire                i_hclk,
	input  wire                i_acc,
	input  wire                i_write,
	input  wire   [MEM_AW-1:0] i_addr,
	input  wire   [DATA_W-1:0] i_wdata,
	output logic  [DATA_W-1:0] o_rdata
);

	logic [DATA_W-1:0] mem [MEM_DEPTH];

	// Single port, read word registered on the access edge
	always_ff @(posedge i_hclk) begin
		if (i_acc) begin
			if (i_write) begin
				mem[i_addr] <= i_wdata;
			end else begin
				o_rdata <= mem[i_addr];
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module req_decode
	import bus_pkg::*, periph_pkg::*;
(
	input  wire                i_hclk,
	input  wire                i_rst_n,
	// Request from the master
	input  wire                i_req_valid,
	output logic               o_req_ready,
	input  wire                i_req_write,
	input  wire   [ADDR_W-1:0] i_req_addr,
	input  wire   [DATA_W-1:0] i_req_wdata,
	// Decoded item towards execute
	output logic               o_dec_valid,
	input  wire                i_dec_ready,
	output logic               o_dec_write,
	output slave_sel_e         o_dec_sel,
	output logic  [MEM_AW-1:0] o_dec_off,
	output logic  [DATA_W-1:0] o_dec_wdata,
	output resp_e              o_dec_err
);

	logic       accept;
	slave_sel_e next_sel;
	logic       bad;

	// Slot frees up when execute takes the current item
	assign o_req_ready = !o_dec_valid || i_dec_ready;
	assign accept      = i_req_valid && o_req_ready;

	// --------------------------------------------------
	// Address decode
	// --------------------------------------------------
	always_comb begin
		bad = (i_req_addr[1:0] != 2'b00);
		case (i_req_addr[31:24])
			REGION_MEM: begin
				next_sel = SEL_MEM;
				bad      = bad || (i_req_addr[23:10] != '0);
			end
			REGION_ALU: begin
				next_sel = SEL_ALU;
				bad      = bad || (i_req_addr[23:4] != '0);
				// Result register is read only
				bad      = bad || (i_req_write && i_req_addr[3:2] == ALU_OFF_RES);
			end
			REGION_MUL: begin
				next_sel = SEL_MUL;
				bad      = bad || (i_req_addr[23:4] != '0);
				// Product halves are read only
				bad      = bad || (i_req_write && (i_req_addr[3:2] == MUL_OFF_LO ||
					i_req_addr[3:2] == MUL_OFF_HI));
			end
			default: begin
				next_sel = SEL_NONE;
				bad      = 1'b1;
			end
		endcase
		if (bad) begin
			next_sel = SEL_NONE;
		end
	end

	// --------------------------------------------------
	// Decode register
	// --------------------------------------------------
	always_ff @(posedge i_hclk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_dec_valid <= 1'b0;
		end else if (accept) begin
			o_dec_valid <= 1'b1;
		end else if (i_dec_ready) begin
			o_dec_valid <= 1'b0;
		end
	end

	// Payload only moves on a transfer
	always_ff @(posedge i_hclk) begin
		if (accept) begin
			o_dec_write <= i_req_write;
			o_dec_sel   <= next_sel;
			o_dec_off   <= i_req_addr[9:2];
			o_dec_wdata <= i_req_wdata;
			o_dec_err   <= bad ? RESP_ERROR : RESP_OKAY;
		end
	end

	// Master keeps a stalled request unchanged
	a_req_hold: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
		i_req_valid && !o_req_ready |=> i_req_valid &&
		$stable({i_req_write, i_req_addr, i_req_wdata}));

endmodule

`default_nettype wire

//--- verilog/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage
	import bus_pkg::*, periph_pkg::*;
(
	input  wire                i_hclk,
	input  wire                i_rst_n,
	// Decoded item from the first stage
	input  wire                i_dec_valid,
	output logic               o_dec_ready,
	input  wire                i_dec_write,
	input  wire   slave_sel_e  i_dec_sel,
	input  wire   [MEM_AW-1:0] i_dec_off,
	input  wire   [DATA_W-1:0] i_dec_wdata,
	input  wire   resp_e       i_dec_err,
	// Response to the master
	output logic               o_rsp_valid,
	input  wire                i_rsp_ready,
	output resp_e              o_rsp_err,
	output logic  [DATA_W-1:0] o_rsp_rdata
);

	logic              accept;
	logic              acc_alu;
	logic              acc_mul;
	logic              acc_mem;
	slave_sel_e        rsp_sel;
	logic [DATA_W-1:0] alu_rdata;
	logic [DATA_W-1:0] mul_rdata;
	logic [DATA_W-1:0] mem_rdata;

	// No new access while a response waits, the held read words stay put
	assign o_dec_ready = !o_rsp_valid || i_rsp_ready;
	assign accept      = i_dec_valid && o_dec_ready;

	assign acc_alu = accept && (i_dec_sel == SEL_ALU);
	assign acc_mul = accept && (i_dec_sel == SEL_MUL);
	assign acc_mem = accept && (i_dec_sel == SEL_MEM);

	// --------------------------------------------------
	// Peripherals
	// --------------------------------------------------
	alu_periph u_alu (
		.i_hclk  (i_hclk),
		.i_rst_n (i_rst_n),
		.i_acc   (acc_alu),
		.i_write (i_dec_write),
		.i_off   (i_dec_off[REG_OFF_W-1:0]),
		.i_wdata (i_dec_wdata),
		.o_rdata (alu_rdata)
	);

	mul_periph u_mul (
		.i_hclk  (i_hclk),
		.i_rst_n (i_rst_n),
		.i_acc   (acc_mul),
		.i_write (i_dec_write),
		.i_off   (i_dec_off[REG_OFF_W-1:0]),
		.i_wdata (i_dec_wdata),
		.o_rdata (mul_rdata)
	);

	data_ram u_ram (
		.i_hclk  (i_hclk),
		.i_acc   (acc_mem),
		.i_write (i_dec_write),
		.i_addr  (i_dec_off),
		.i_wdata (i_dec_wdata),
		.o_rdata (mem_rdata)
	);

	// --------------------------------------------------
	// Response slot
	// --------------------------------------------------
	always_ff @(posedge i_hclk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_rsp_valid <= 1'b0;
			rsp_sel     <= SEL_NONE;
			o_rsp_err   <= RESP_OKAY;
		end else if (accept) begin
			o_rsp_valid <= 1'b1;
			rsp_sel     <= i_dec_sel;
			o_rsp_err   <= i_dec_err;
		end else if (i_rsp_ready) begin
			o_rsp_valid <= 1'b0;
		end
	end

	// Read word of the peripheral that served this item
	always_comb begin
		case (rsp_sel)
			SEL_ALU: o_rsp_rdata = alu_rdata;
			SEL_MUL: o_rsp_rdata = mul_rdata;
			SEL_MEM: o_rsp_rdata = mem_rdata;
			default: o_rsp_rdata = '0;
		endcase
	end

	// RAM word may be X after a write, so compare with ===
	a_rsp_hold: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
		o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp_err) &&
		($past(o_rsp_rdata) === o_rsp_rdata));

endmodule

`default_nettype wire

//--- verilog/bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module bus_top
	import bus_pkg::*, periph_pkg::*;
(
	input  wire                i_hclk,
	input  wire                i_rst_n,
	// Request stream
	input  wire                i_req_valid,
	output logic               o_req_ready,
	input  wire                i_req_write,
	input  wire   [ADDR_W-1:0] i_req_addr,
	input  wire   [DATA_W-1:0] i_req_wdata,
	// Response stream
	output logic               o_rsp_valid,
	input  wire                i_rsp_ready,
	output resp_e              o_rsp_err,
	output logic  [DATA_W-1:0] o_rsp_rdata
);

	// --------------------------------------------------
	// Decode to execute
	// --------------------------------------------------
	logic              dec_valid;
	logic              dec_ready;
	logic              dec_write;
	slave_sel_e        dec_sel;
	logic [MEM_AW-1:0] dec_off;
	logic [DATA_W-1:0] dec_wdata;
	resp_e             dec_err;

	req_decode u_decode (
		.i_hclk      (i_hclk),
		.i_rst_n     (i_rst_n),
		.i_req_valid (i_req_valid),
		.o_req_ready (o_req_ready),
		.i_req_write (i_req_write),
		.i_req_addr  (i_req_addr),
		.i_req_wdata (i_req_wdata),
		.o_dec_valid (dec_valid),
		.i_dec_ready (dec_ready),
		.o_dec_write (dec_write),
		.o_dec_sel   (dec_sel),
		.o_dec_off   (dec_off),
		.o_dec_wdata (dec_wdata),
		.o_dec_err   (dec_err)
	);

	exec_stage u_exec (
		.i_hclk      (i_hclk),
		.i_rst_n     (i_rst_n),
		.i_dec_valid (dec_valid),
		.o_dec_ready (dec_ready),
		.i_dec_write (dec_write),
		.i_dec_sel   (dec_sel),
		.i_dec_off   (dec_off),
		.i_dec_wdata (dec_wdata),
		.i_dec_err   (dec_err),
		.o_rsp_valid (o_rsp_valid),
		.i_rsp_ready (i_rsp_ready),
		.o_rsp_err   (o_rsp_err),
		.o_rsp_rdata (o_rsp_rdata)
	);

endmodule

`default_nettype wire

//--- tests/tb_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_top
	import bus_pkg::*, periph_pkg::*;
();

	logic              i_hclk;
	logic              i_rst_n;
	logic              i_req_valid;
	logic              o_req_ready;
	logic              i_req_write;
	logic [ADDR_W-1:0] i_req_addr;
	logic [DATA_W-1:0] i_req_wdata;
	logic              o_rsp_valid;
	logic              i_rsp_ready;
	resp_e             o_rsp_err;
	logic [DATA_W-1:0] o_rsp_rdata;

	// Shadow of the peripheral state
	logic [DATA_W-1:0] alu_a;
	logic [DATA_W-1:0] alu_b;
	alu_op_e           alu_op;
	logic [DATA_W-1:0] mul_a;
	logic [DATA_W-1:0] mul_b;
	logic [DATA_W-1:0] mem_shadow [int];

	// Expected responses in request order
	resp_e             exp_err_q [$];
	logic [DATA_W-1:0] exp_data_q [$];
	logic              exp_chk_q [$];

	int   n_issued;
	int   cycles;
	logic bp_on;

	bus_top dut (
		.i_hclk      (i_hclk),
		.i_rst_n     (i_rst_n),
		.i_req_valid (i_req_valid),
		.o_req_ready (o_req_ready),
		.i_req_write (i_req_write),
		.i_req_addr  (i_req_addr),
		.i_req_wdata (i_req_wdata),
		.o_rsp_valid (o_rsp_valid),
		.i_rsp_ready (i_rsp_ready),
		.o_rsp_err   (o_rsp_err),
		.o_rsp_rdata (o_rsp_rdata)
	);

	initial begin
		i_hclk = 1'b0;
		forever #4 i_hclk = ~i_hclk;
	end

	// --------------------------------------------------
	// Reporting
	// --------------------------------------------------
	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_resp(input string name, input resp_e exp, input resp_e act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	function automatic logic [DATA_W-1:0] alu_ref(input alu_op_e op,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLL: return a << (b % 32);
			ALU_SRL: return a >> (b % 32);
			default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		endcase
	endfunction

	function automatic void predict(input logic wr, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, output resp_e err,
		output logic [DATA_W-1:0] rdata, output logic chk);
		logic [7:0]          region;
		logic [1:0]          off;
		int                  idx;
		logic                bad;
		logic [2*DATA_W-1:0] prod;
		region = addr[31:24];
		off    = addr[3:2];
		idx    = addr[9:2];
		bad    = (addr[1:0] != 2'b00);
		rdata  = '0;
		chk    = !wr;
		if (region == REGION_MEM)
			bad = bad || (addr[23:10] != '0);
		else if (region == REGION_ALU)
			bad = bad || (addr[23:4] != '0) || (wr && off == ALU_OFF_RES);
		else if (region == REGION_MUL)
			bad = bad || (addr[23:4] != '0) ||
				(wr && (off == MUL_OFF_LO || off == MUL_OFF_HI));
		else
			bad = 1'b1;
		err = bad ? RESP_ERROR : RESP_OKAY;
		if (bad) begin
			chk = 1'b0;
			return;
		end
		prod = {32'h0, mul_a} * {32'h0, mul_b};
		if (region == REGION_MEM) begin
			if (wr)
				mem_shadow[idx] = wdata;
			else if (mem_shadow.exists(idx))
				rdata = mem_shadow[idx];
			else
				chk = 1'b0;
		end else if (region == REGION_ALU) begin
			case (off)
				ALU_OFF_A: begin
					if (wr)
						alu_a = wdata;
					else
						rdata = alu_a;
				end
				ALU_OFF_B: begin
					if (wr)
						alu_b = wdata;
					else
						rdata = alu_b;
				end
				ALU_OFF_OP: begin
					if (wr)
						alu_op = alu_op_e'(wdata[2:0]);
					else
						rdata = 32'(alu_op);
				end
				default: rdata = alu_ref(alu_op, alu_a, alu_b);
			endcase
		end else begin
			case (off)
				MUL_OFF_A: begin
					if (wr)
						mul_a = wdata;
					else
						rdata = mul_a;
				end
				MUL_OFF_B: begin
					if (wr)
						mul_b = wdata;
					else
						rdata = mul_b;
				end
				MUL_OFF_LO: rdata = prod[31:0];
				default:    rdata = prod[63:32];
			endcase
		end
	endfunction

	// --------------------------------------------------
	// Request driver
	// --------------------------------------------------
	function automatic logic [ADDR_W-1:0] reg_addr(input logic [7:0] region, input int off);
		return {region, 20'h0, 2'(off), 2'b00};
	endfunction

	function automatic logic [ADDR_W-1:0] mem_addr(input int idx);
		return {REGION_MEM, 14'h0, 8'(idx), 2'b00};
	endfunction

	// Holds the request until the DUT takes it; ready is settled 1 ns after the falling edge
	task automatic issue(input logic wr, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata);
		resp_e             err;
		logic [DATA_W-1:0] rdata;
		logic              chk;
		@(negedge i_hclk);
		i_req_valid = 1'b1;
		i_req_write = wr;
		i_req_addr  = addr;
		i_req_wdata = wdata;
		#1;
		while (!o_req_ready) begin
			@(negedge i_hclk);
			#1;
		end
		predict(wr, addr, wdata, err, rdata, chk);
		exp_err_q.push_back(err);
		exp_data_q.push_back(rdata);
		exp_chk_q.push_back(chk);
		n_issued++;
		@(posedge i_hclk);
	endtask

	task automatic drain();
		@(negedge i_hclk);
		i_req_valid = 1'b0;
		while (exp_err_q.size() != 0)
			@(negedge i_hclk);
	endtask

	// --------------------------------------------------
	// Response side
	// --------------------------------------------------
	initial begin
		int run;
		run = 0;
		i_rsp_ready = 1'b1;
		forever begin
			@(negedge i_hclk);
			if (!bp_on) begin
				i_rsp_ready = 1'b1;
			end else if (run == 0) begin
				// Stall phases of random length and low about 30% of the time
				i_rsp_ready = ($urandom % 10) >= 3;
				run = 1 + $urandom % 4;
			end else begin
				run--;
			end
		end
	end

	initial begin
		logic chk;
		forever begin
			@(negedge i_hclk);
			#1;
			if (o_rsp_valid && i_rsp_ready) begin
				if (exp_err_q.size() == 0) begin
					$display("A response arrived with no request outstanding");
					stop_run();
				end
				chk = exp_chk_q.pop_front();
				check_resp("o_rsp_err", exp_err_q.pop_front(), o_rsp_err);
				if (chk)
					check_word("o_rsp_rdata", exp_data_q.pop_front(), o_rsp_rdata);
				else
					void'(exp_data_q.pop_front());
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles <= 20 * n_issued + 100) begin
			@(posedge i_hclk);
			cycles++;
		end
		$display("Timeout, responses stopped arriving after %0d cycles", cycles);
		stop_run();
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial begin
		int                idx [16];
		logic [DATA_W-1:0] a;
		void'($urandom(95062));
		n_issued    = 0;
		bp_on       = 1'b0;
		alu_a       = '0;
		alu_b       = '0;
		alu_op      = ALU_ADD;
		mul_a       = '0;
		mul_b       = '0;
		i_rst_n     = 1'b0;
		i_req_valid = 1'b0;
		i_req_write = 1'b0;
		i_req_addr  = '0;
		i_req_wdata = '0;
		repeat (2) @(negedge i_hclk);
		i_rst_n = 1'b1;
		@(negedge i_hclk);
		check_flag("o_rsp_valid", 1'b0, o_rsp_valid);
		issue(1'b0, reg_addr(REGION_ALU, ALU_OFF_OP), '0);
		issue(1'b0, reg_addr(REGION_ALU, ALU_OFF_A), '0);
		drain();

		// Memory round trip
		foreach (idx[i]) begin
			idx[i] = $urandom % MEM_DEPTH;
			issue(1'b1, mem_addr(idx[i]), $urandom);
		end
		foreach (idx[i])
			issue(1'b0, mem_addr(idx[i]), '0);
		drain();

		// Every opcode and SLT with a negative A
		for (int op = 0; op < 8; op++) begin
			a = (op == ALU_SLT) ? ($urandom | 32'h8000_0000) : $urandom;
			issue(1'b1, reg_addr(REGION_ALU, ALU_OFF_A), a);
			issue(1'b1, reg_addr(REGION_ALU, ALU_OFF_B), $urandom);
			issue(1'b1, reg_addr(REGION_ALU, ALU_OFF_OP), 32'(op));
			issue(1'b0, reg_addr(REGION_ALU, ALU_OFF_RES), '0);
		end
		drain();

		// Multiplier with all ones in the last pair
		for (int n = 0; n < 6; n++) begin
			issue(1'b1, reg_addr(REGION_MUL, MUL_OFF_A), (n == 5) ? '1 : $urandom);
			issue(1'b1, reg_addr(REGION_MUL, MUL_OFF_B), (n == 5) ? '1 : $urandom);
			issue(1'b0, reg_addr(REGION_MUL, MUL_OFF_LO), '0);
			issue(1'b0, reg_addr(REGION_MUL, MUL_OFF_HI), '0);
		end
		drain();

		// Error cases followed by reads of the state they must not touch
		issue(1'b1, mem_addr(0), 32'h1234_5678);
		issue(1'b1, 32'h3000_0000, $urandom);
		issue(1'b1, reg_addr(REGION_ALU, ALU_OFF_A) | 32'h1, $urandom);
		issue(1'b1, reg_addr(REGION_ALU, ALU_OFF_A) | 32'h10, $urandom);
		issue(1'b1, mem_addr(0) | 32'h400, $urandom);
		issue(1'b1, reg_addr(REGION_ALU, ALU_OFF_RES), $urandom);
		issue(1'b1, reg_addr(REGION_MUL, MUL_OFF_LO), $urandom);
		issue(1'b1, reg_addr(REGION_MUL, MUL_OFF_HI), $urandom);
		issue(1'b0, mem_addr(0), '0);
		issue(1'b0, reg_addr(REGION_ALU, ALU_OFF_A), '0);
		issue(1'b0, reg_addr(REGION_ALU, ALU_OFF_RES), '0);
		issue(1'b0, reg_addr(REGION_MUL, MUL_OFF_LO), '0);
		drain();

		// Mixed traffic under back-pressure
		bp_on = 1'b1;
		for (int n = 0; n < 300; n++) begin
			case ($urandom % 8)
				0, 1, 2: issue($urandom % 2, mem_addr($urandom % 16), $urandom);
				3, 4:    issue($urandom % 2, reg_addr(REGION_ALU, $urandom % 4), $urandom);
				5, 6:    issue($urandom % 2, reg_addr(REGION_MUL, $urandom % 4), $urandom);
				default: issue($urandom % 2, $urandom, $urandom);
			endcase
		end
		drain();
		bp_on = 1'b0;

		// Idle cycles so a stray or duplicated response still shows up
		repeat (4) @(negedge i_hclk);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
verilog/bus_pkg.sv
verilog/periph_pkg.sv
verilog/alu_periph.sv
verilog/mul_periph.sv
verilog/data_ram.sv
verilog/req_decode.sv
verilog/exec_stage.sv
verilog/bus_top.sv
tests/tb_bus_top.sv

//--- Bender.yml
package:
  name: bus_top

sources:
  - verilog/bus_pkg.sv
  - verilog/periph_pkg.sv
  - verilog/alu_periph.sv
  - verilog/mul_periph.sv
  - verilog/data_ram.sv
  - verilog/req_decode.sv
  - verilog/exec_stage.sv
  - verilog/bus_top.sv
  - target: test
    files:
      - tests/tb_bus_top.sv
